// File: calc_defs.svh
// Width and iteration constants for the calculator core, included by RTL and testbench
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// Display word, sign in the top bit
`define CALC_W 16
`define MAG_W 15

// Each entered digit scales the operand by this
`define DIGIT_BASE 10

// One shift-add pass per magnitude bit
`define MULT_STEPS 15

`endif

// File: calc_pkg.sv
// Shared types for the calculator RTL, imported by every design module
`default_nettype none

`include "calc_defs.svh"

package calc_pkg;

    typedef enum logic [3:0] {
        WAIT_OP1, WAIT_MULT_OP1, ADD_KEY_OP1,
        WAIT_OP2, WAIT_MULT_OP2, ADD_KEY_OP2,
        SEND_TO_COMPUTE, WAIT_COMPUTE, SHOW_RESULT
    } calc_state_t;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_code_t;

    typedef struct packed {
        logic              sign;
        logic [`MAG_W-1:0] mag;
    } signmag_t;

    typedef struct packed {
        signmag_t a;
        signmag_t b;
        logic     sub;
    } arith_req_t;

    typedef struct packed {
        signmag_t a;
        signmag_t b;
    } mult_req_t;

    // Orders from the controller to the operand registers
    typedef struct packed {
        logic [1:0] sel;
        logic       negate;
        logic       load_product;
        logic       add_digit;
        logic       clear;
    } builder_cmd_t;

endpackage

`default_nettype wire

// File: calc_fsm.sv
// Calculator controller, sequences digit entry, operator latching and the final computation
`default_nettype none

`include "calc_defs.svh"

module calc_fsm import calc_pkg::*; (
    input  logic         clk,
    input  logic         nRST,
    input  logic [3:0]   keypad_input,
    input  logic         read_input,
    input  op_code_t     operator_input,
    input  logic         equal_input,
    input  logic         mult_finish,
    input  logic         add_finish,
    input  signmag_t     op1,
    input  signmag_t     op2,
    output builder_cmd_t cmd,
    output logic [3:0]   digit,
    output mult_req_t    mult_req,
    output logic         mult_start,
    output arith_req_t   arith_req,
    output logic         add_start,
    output logic         key_read,
    output logic         complete,
    output logic         result_sel
);
    localparam signmag_t BASE_NUM = '{sign: 1'b0, mag: `MAG_W'(`DIGIT_BASE)};

    calc_state_t state, next_state;
    op_code_t    op_q;
    logic        in_entry, sel_op2;
    logic        op_key, neg_key;
    logic        take_equal, take_op, take_neg, take_digit;

    assign in_entry = (state == WAIT_OP1) || (state == WAIT_OP2);
    assign sel_op2  = (state == WAIT_OP2) || (state == WAIT_MULT_OP2) || (state == ADD_KEY_OP2);
    assign op_key   = operator_input inside {OP_ADD, OP_SUB, OP_MUL};
    assign neg_key  = (operator_input == OP_NEG);

    // Equal wins, then operator, then negate, then digit
    assign take_equal = (state == WAIT_OP2) && equal_input;
    assign take_op    = in_entry && !take_equal && op_key;
    assign take_neg   = in_entry && !take_equal && neg_key;
    assign take_digit = in_entry && !take_equal && !op_key && !neg_key && read_input;

    assign result_sel = (op_q == OP_MUL);

    always_comb begin
        next_state = state;
        case (state)
            WAIT_OP1:
                if (take_op) next_state = WAIT_OP2;
                else if (take_digit) next_state = WAIT_MULT_OP1;
            WAIT_MULT_OP1:
                if (mult_finish) next_state = ADD_KEY_OP1;
            ADD_KEY_OP1:     next_state = WAIT_OP1;
            WAIT_OP2:
                if (take_equal) next_state = SEND_TO_COMPUTE;
                else if (take_digit) next_state = WAIT_MULT_OP2;
            WAIT_MULT_OP2:
                if (mult_finish) next_state = ADD_KEY_OP2;
            ADD_KEY_OP2:     next_state = WAIT_OP2;
            SEND_TO_COMPUTE: next_state = WAIT_COMPUTE;
            WAIT_COMPUTE:
                if (add_finish || mult_finish) next_state = SHOW_RESULT;
            default:         next_state = WAIT_OP1;
        endcase
    end

    always_comb begin
        cmd              = '0;
        cmd.sel          = {1'b0, sel_op2};
        cmd.negate       = take_neg;
        cmd.load_product = ((state == WAIT_MULT_OP1) || (state == WAIT_MULT_OP2)) && mult_finish;
        cmd.add_digit    = (state == ADD_KEY_OP1) || (state == ADD_KEY_OP2);
        cmd.clear        = (state == SHOW_RESULT);
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= WAIT_OP1;
            op_q       <= OP_NONE;
            key_read   <= 1'b0;
            complete   <= 1'b0;
            mult_start <= 1'b0;
            add_start  <= 1'b0;
        end else begin
            state      <= next_state;
            key_read   <= take_op || take_neg || cmd.add_digit;
            complete   <= (state == SHOW_RESULT);
            mult_start <= take_digit || ((state == SEND_TO_COMPUTE) && (op_q == OP_MUL));
            add_start  <= (state == SEND_TO_COMPUTE) && (op_q != OP_MUL);
            if (take_op) begin
                op_q <= operator_input;
            end
        end
    end

    // Operands handed to the arithmetic units
    always_ff @(posedge clk) begin
        if (take_digit) begin
            digit      <= keypad_input;
            mult_req.a <= sel_op2 ? op2 : op1;
            mult_req.b <= BASE_NUM;
        end else if (state == SEND_TO_COMPUTE) begin
            mult_req.a <= op1;
            mult_req.b <= op2;
        end
        if (state == SEND_TO_COMPUTE) begin
            arith_req <= '{a: op1, b: op2, sub: (op_q == OP_SUB)};
        end
    end

    a_ack_excl: assert property (@(posedge clk) disable iff (!nRST) !(key_read && complete));

endmodule

`default_nettype wire

// File: shift_add_multiplier.sv
// Iterative sign-magnitude multiplier, one shift-add step per clock after a start pulse
`default_nettype none

`include "calc_defs.svh"

module shift_add_multiplier import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  logic      start,
    input  mult_req_t req,
    output signmag_t  product,
    output logic      finish
);
    localparam int CNT_W = $clog2(`MULT_STEPS + 1);

    logic [CNT_W-1:0]  count;
    logic [`MAG_W-1:0] mcand, mplier, acc;
    logic              sign_q;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count  <= '0;
            finish <= 1'b0;
        end else begin
            // Last step in flight means the product is ready next cycle
            finish <= (count == CNT_W'(1));
            if (start) begin
                count <= CNT_W'(`MULT_STEPS);
            end else if (count != '0) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= req.a.mag;
            mplier <= req.b.mag;
            acc    <= '0;
            sign_q <= req.a.sign ^ req.b.sign;
        end else if (count != '0) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // High bits fall off, giving the wrap
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // No negative zero
    assign product = '{sign: sign_q && (acc != '0), mag: acc};

    a_no_restart: assert property (@(posedge clk) disable iff (!nRST) start |-> count == '0);

endmodule

`default_nettype wire

// File: signmag_adder.sv
// Registered sign-magnitude adder and subtractor, result one cycle after start
`default_nettype none

module signmag_adder import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       start,
    input  arith_req_t req,
    output signmag_t   sum,
    output logic       finish
);
    logic     b_sign;
    signmag_t next_sum;

    always_comb begin
        // Subtract is add with b's sign flipped
        b_sign = req.b.sign ^ req.sub;
        if (req.a.sign == b_sign) begin
            next_sum.mag  = req.a.mag + req.b.mag;
            next_sum.sign = req.a.sign;
        end else if (req.a.mag >= req.b.mag) begin
            next_sum.mag  = req.a.mag - req.b.mag;
            next_sum.sign = req.a.sign;
        end else begin
            next_sum.mag  = req.b.mag - req.a.mag;
            next_sum.sign = b_sign;
        end
        if (next_sum.mag == '0) begin
            next_sum.sign = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sum <= next_sum;
        end
    end

    a_one_cycle: assert property (@(posedge clk) disable iff (!nRST) start |=> finish);

endmodule

`default_nettype wire

// File: operand_builder.sv
// Holds both calculator operands and applies the controller's sign, load and digit orders
`default_nettype none

`include "calc_defs.svh"

module operand_builder import calc_pkg::*; (
    input  logic         clk,
    input  logic         nRST,
    input  builder_cmd_t cmd,
    input  logic [3:0]   digit,
    input  signmag_t     product,
    output signmag_t     op1,
    output signmag_t     op2
);
    signmag_t upd;
    logic     write_en;

    assign write_en = cmd.negate || cmd.load_product || cmd.add_digit;

    always_comb begin
        upd = (cmd.sel == 2'd1) ? op2 : op1;
        if (cmd.negate) begin
            upd.sign = ~upd.sign;
        end
        // Sign survives the ten-times load
        if (cmd.load_product) begin
            upd.mag = product.mag;
        end
        if (cmd.add_digit) begin
            upd.mag = upd.mag + {{(`MAG_W-4){1'b0}}, digit};
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op1 <= '0;
            op2 <= '0;
        end else if (cmd.clear) begin
            op1 <= '0;
            op2 <= '0;
        end else if (write_en) begin
            if (cmd.sel == 2'd1) begin
                op2 <= upd;
            end else begin
                op1 <= upd;
            end
        end
    end

endmodule

`default_nettype wire

// File: calc_top.sv
// Calculator core top level, wires the controller to operands, adder and multiplier
`default_nettype none

`include "calc_defs.svh"

module calc_top import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] keypad_input,
    input  logic       read_input,
    input  op_code_t   operator_input,
    input  logic       equal_input,
    output logic       key_read,
    output logic       complete,
    output signmag_t   display_output
);
    builder_cmd_t      cmd;
    logic [3:0]        digit;
    signmag_t          op1, op2, product, sum, result;
    mult_req_t         mult_req;
    arith_req_t        arith_req;
    logic              mult_start, mult_finish, add_start, add_finish, result_sel;
    logic [`CALC_W-1:0] shown_q;

    calc_fsm u_fsm (
        .clk, .nRST, .keypad_input, .read_input, .operator_input, .equal_input,
        .mult_finish, .add_finish, .op1, .op2,
        .cmd, .digit, .mult_req, .mult_start, .arith_req, .add_start,
        .key_read, .complete, .result_sel
    );

    operand_builder u_operands (
        .clk, .nRST, .cmd, .digit, .product, .op1, .op2
    );

    shift_add_multiplier u_mult (
        .clk, .nRST, .start(mult_start), .req(mult_req), .product, .finish(mult_finish)
    );

    signmag_adder u_adder (
        .clk, .nRST, .start(add_start), .req(arith_req), .sum, .finish(add_finish)
    );

    assign result = result_sel ? product : sum;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            shown_q <= '0;
        end else if (complete) begin
            shown_q <= result;
        end
    end

    // New value shows in the complete cycle, then the held copy takes over
    assign display_output = complete ? result : signmag_t'(shown_q);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and reset source, 4-unit clock with reset held low for the first cycles
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic nRST
);
    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

// File: calc_checker.sv
// Testbench monitor for the calculator, checks acknowledges and display values and counts errors
`default_nettype none

`include "calc_defs.svh"

module calc_checker import calc_pkg::*; (
    input  logic               clk,
    input  logic               nRST,
    input  logic               key_read,
    input  logic               complete,
    input  signmag_t           display_output,
    input  logic               ack_window,
    input  logic               done_window,
    input  logic               lost_ack,
    input  logic [`CALC_W-1:0] expected,
    output int                 errors,
    output int                 checks
);
    logic [`CALC_W-1:0] held;
    int                 err_cnt = 0;
    int                 chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    task automatic report_mismatch(input string name, input logic [`CALC_W-1:0] got,
                                   input logic [`CALC_W-1:0] want);
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h at time %0t", name, got, want, $time);
        err_cnt++;
    endtask

    // Outputs settle after the rising edge, so the edge sees last cycle's values
    always @(posedge clk) begin
        if (!nRST) begin
            held = '0;
            if (key_read || complete) begin
                report_mismatch("key_read|complete", {{(`CALC_W-2){1'b0}}, key_read, complete},
                                '0);
            end
        end else begin
            if (key_read) begin
                chk_cnt++;
                if (!ack_window) begin
                    report_mismatch("key_read", `CALC_W'(1), '0);
                end
            end
            if (complete) begin
                chk_cnt++;
                if (!done_window) begin
                    report_mismatch("complete", `CALC_W'(1), '0);
                end else if (display_output !== expected) begin
                    report_mismatch("display_output", display_output, expected);
                end
                held = display_output;
            end else if (display_output !== held) begin
                // Display must hold between results
                report_mismatch("display_output", display_output, held);
            end
            if (lost_ack) begin
                err_cnt++;
                if (done_window) begin
                    $display("ERROR: no complete pulse came after the equal key");
                end else begin
                    $display("ERROR: no key_read pulse came after a key press");
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_calc.sv
// Testbench top for the calculator core, replays the key lines of calc_tests.txt into the DUT
`default_nettype none

`include "calc_defs.svh"

module tb_calc import calc_pkg::*; ();
    // Slowest key is about 20 cycles, leaves room for the idle gap
    localparam int KEY_CYCLES = 40;
    localparam int MARGIN     = 100;

    logic               clk;
    logic               nRST;
    logic [3:0]         keypad_input;
    logic               read_input;
    op_code_t           operator_input;
    logic               equal_input;
    logic               key_read;
    logic               complete;
    signmag_t           display_output;
    logic               ack_window;
    logic               done_window;
    logic               lost_ack;
    logic [`CALC_W-1:0] expected;
    int                 chk_errors;
    int                 chk_checks;

    string              test_keys[$];
    logic [`CALC_W-1:0] test_exp[$];
    int                 total_keys   = 0;
    int                 tb_errors    = 0;
    bit                 tests_loaded = 1'b0;

    tb_clock_gen u_clock (.clk, .nRST);

    calc_top DUT (
        .clk, .nRST, .keypad_input, .read_input, .operator_input, .equal_input,
        .key_read, .complete, .display_output
    );

    calc_checker u_checker (
        .clk, .nRST, .key_read, .complete, .display_output,
        .ack_window, .done_window, .lost_ack, .expected,
        .errors(chk_errors), .checks(chk_checks)
    );

    function automatic bit is_key(input byte c);
        return (c >= "0" && c <= "9") || (c == "N") || (c == "+") || (c == "-")
            || (c == "*") || (c == "=");
    endfunction

    task automatic load_tests;
        int                 fd;
        int                 eq_pos;
        string              line;
        string              keys;
        logic [`CALC_W-1:0] value;
        fd = $fopen("calc_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open calc_tests.txt");
            tb_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            keys   = "";
            eq_pos = -1;
            for (int i = 0; i < line.len() && eq_pos < 0; i++) begin
                if (is_key(line[i])) begin
                    keys = {keys, line.substr(i, i)};
                end
                if (line[i] == "=") begin
                    eq_pos = i;
                end
            end
            // Comment and blank lines
            if (line.len() == 0 || line[0] == "#" || eq_pos < 0) begin
                continue;
            end
            if ($sscanf(line.substr(eq_pos + 1, line.len() - 1), "%h", value) != 1) begin
                $display("ERROR: test line has no expected value: %s", line);
                tb_errors++;
                continue;
            end
            test_keys.push_back(keys);
            test_exp.push_back(value);
            total_keys += keys.len();
        end
        $fclose(fd);
    endtask

    // One key as a one-cycle strobe, then wait for its acknowledge
    task automatic send_key(input byte k, input logic [`CALC_W-1:0] want);
        int   cycles;
        logic seen;
        @(negedge clk);
        cycles = 0;
        seen   = 1'b0;
        case (k)
            "N": operator_input = OP_NEG;
            "+": operator_input = OP_ADD;
            "-": operator_input = OP_SUB;
            "*": operator_input = OP_MUL;
            "=": begin
                expected    = want;
                equal_input = 1'b1;
            end
            default: begin
                keypad_input = 4'(k - "0");
                read_input   = 1'b1;
            end
        endcase
        ack_window  = (k != "=");
        done_window = (k == "=");
        while (!seen && cycles < KEY_CYCLES) begin
            @(negedge clk);
            read_input     = 1'b0;
            operator_input = OP_NONE;
            equal_input    = 1'b0;
            seen           = (k == "=") ? complete : key_read;
            cycles++;
        end
        lost_ack = !seen;
        @(negedge clk);
        lost_ack    = 1'b0;
        ack_window  = 1'b0;
        done_window = 1'b0;
    endtask

    task automatic run_test(input string keys, input logic [`CALC_W-1:0] want);
        for (int i = 0; i < keys.len(); i++) begin
            repeat ($urandom % 4) @(negedge clk);
            send_key(keys[i], want);
        end
    endtask

    initial begin
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        ack_window     = 1'b0;
        done_window    = 1'b0;
        lost_ack       = 1'b0;
        expected       = '0;
        void'($urandom(31899));
        load_tests();
        tests_loaded = 1'b1;
        wait (nRST === 1'b1);
        for (int t = 0; t < test_keys.size(); t++) begin
            run_test(test_keys[t], test_exp[t]);
        end
        repeat (4) @(negedge clk);
        $display("%0d tests, %0d checks, %0d errors", test_keys.size(), chk_checks,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0 && test_keys.size() > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of keys in the tests file
    initial begin
        wait (tests_loaded);
        repeat (total_keys * KEY_CYCLES + MARGIN) @(posedge clk);
        $display("ERROR: watchdog ran out after %0d cycles, the run is stopped",
                 total_keys * KEY_CYCLES + MARGIN);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: calc_tests.txt
# Keys before '=': digits, N for negate, + - * for operators, spaces ignored
# After '=': expected display word in hex, bit 15 sign and bits 14:0 magnitude
123 + 45 = 00A8
7 - 20 = 800D
20 - 7 = 000D
25 - 25 = 0000
N 5 - N 5 = 0000
N 12 * 3 = 8024
N 12 * N 3 = 0024
N N 9 + 4 = 000D
300 * 200 = 6A60
40000 + 0 = 1C40
99999 + 1 = 06A0
0 * N 7 = 0000
N 3 + 10 = 0007
N 8 - 8 = 8010
181 * 181 = 7FF9
N 256 * 129 = 8100

// File: all.f
+incdir+.
calc_pkg.sv
calc_fsm.sv
shift_add_multiplier.sv
signmag_adder.sv
operand_builder.sv
calc_top.sv
tb_clock_gen.sv
calc_checker.sv
tb_calc.sv

// File: Makefile
TOP = tb_calc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module calc_top -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o sim_calc
	./obj_dir/sim_calc | tee sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
